// ==== edge_aggr_pkg.sv ====
// edge aggregation package with sizes, stream commands and beat structs
`default_nettype none

package edge_aggr_pkg;

    // bank count and bank index width
    localparam int NUM_BANKS  = 4;
    localparam int BANK_SEL_W = 2;

    // feature vector geometry, two elements per beat
    localparam int FV_NUM_MAX = 16;
    localparam int FV_W       = 16;
    localparam int PAIR_NUM   = FV_NUM_MAX / 2;

    localparam int NODE_ID_W  = 10;
    // wide enough for a pair count of PAIR_NUM
    localparam int BEAT_CNT_W = 4;

    // command on the last beat of a stream
    typedef enum logic [1:0] {
        CMD_HOLD      = 2'd0,
        CMD_WRITEBACK = 2'd1,
        CMD_FINAL     = 2'd2
    } aggr_cmd_t;

    // one beat of feature data
    typedef logic [1:0][FV_W-1:0] fv_pair_t;

    // input beat from the edge PE
    typedef struct packed {
        logic [NODE_ID_W-1:0] node_id;
        logic                 sos;
        logic                 eos;
        aggr_cmd_t            cmd;
        fv_pair_t             data;
    } edge_beat_t;

    // result kind on the output port
    typedef enum logic {
        KIND_PARTIAL = 1'b0,
        KIND_FINAL   = 1'b1
    } out_kind_t;

    // output beat of a bank and of the top level
    typedef struct packed {
        logic [NODE_ID_W-1:0] node_id;
        logic                 sos;
        logic                 eos;
        out_kind_t            kind;
        fv_pair_t             data;
    } bank_beat_t;

endpackage

`default_nettype wire

// ==== edge_bank_dispatch.sv ====
// input dispatcher that routes each beat to its accumulation bank by node id
`default_nettype none

module edge_bank_dispatch (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  edge_aggr_pkg::edge_beat_t           in_beat,
    output logic                                in_ready,
    input  logic [edge_aggr_pkg::NUM_BANKS-1:0] bank_busy,
    output logic [edge_aggr_pkg::NUM_BANKS-1:0] beat_valid,
    output edge_aggr_pkg::edge_beat_t           bank_beat
);

    logic [edge_aggr_pkg::BANK_SEL_W-1:0] sel;
    logic                                 closing;
    logic                                 running;
    logic                                 accept;

    // bank index from the low node id bits
    assign sel = in_beat.node_id[edge_aggr_pkg::BANK_SEL_W-1:0];

    // registered beat ends a non-hold stream in the selected bank,
    // whose busy flag only rises next cycle
    assign closing = beat_valid[sel] && bank_beat.eos
                     && (bank_beat.cmd != edge_aggr_pkg::CMD_HOLD);

    assign in_ready = running && !bank_busy[sel] && !closing;
    assign accept   = in_valid && in_ready;

    // one-hot beat valid, one cycle per accepted beat
    always_ff @(posedge clk) begin
        if (reset) begin
            running    <= 1'b0;
            beat_valid <= '0;
        end else begin
            running    <= 1'b1;
            beat_valid <= '0;
            if (accept) begin
                beat_valid[sel] <= 1'b1;
            end
        end
    end

    // shared beat bus register
    always_ff @(posedge clk) begin
        if (accept) begin
            bank_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

// ==== edge_bank.sv ====
// accumulation bank that sums node streams and drains results over req/ack
`default_nettype none

module edge_bank (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      beat_valid,
    input  edge_aggr_pkg::edge_beat_t bank_beat,
    output logic                      busy,
    output logic                      req,
    input  logic                      ack,
    input  logic                      take,
    output edge_aggr_pkg::bank_beat_t out_beat
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STREAM,
        ST_DRAIN,
        ST_RELEASE
    } bank_state_t;

    bank_state_t state;

    // accumulator, one entry per element pair
    edge_aggr_pkg::fv_pair_t [edge_aggr_pkg::PAIR_NUM-1:0] acc;
    edge_aggr_pkg::fv_pair_t                               sum;

    logic [edge_aggr_pkg::BEAT_CNT_W-1:0] pair_cnt;
    logic [edge_aggr_pkg::BEAT_CNT_W-1:0] pair_len;
    logic [edge_aggr_pkg::BEAT_CNT_W-2:0] idx;
    logic                                 last_pair;
    logic [edge_aggr_pkg::NODE_ID_W-1:0]  cur_node;
    edge_aggr_pkg::aggr_cmd_t             cur_cmd;

    assign idx       = pair_cnt[edge_aggr_pkg::BEAT_CNT_W-2:0];
    assign last_pair = (pair_cnt == pair_len - 1'b1);

    // element-wise add, wraps modulo 2^FV_W
    always_comb begin
        for (int e = 0; e < 2; e++) begin
            sum[e] = acc[idx][e] + bank_beat.data[e];
        end
    end

    assign busy = (state == ST_DRAIN) || (state == ST_RELEASE);
    assign req  = (state == ST_DRAIN);

    // current drain beat, valid whenever req is high
    always_comb begin
        out_beat.node_id = cur_node;
        out_beat.sos     = (pair_cnt == '0);
        out_beat.eos     = last_pair;
        out_beat.kind    = (cur_cmd == edge_aggr_pkg::CMD_FINAL) ?
                           edge_aggr_pkg::KIND_FINAL : edge_aggr_pkg::KIND_PARTIAL;
        out_beat.data    = acc[idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            acc      <= '0;
            pair_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_STREAM: begin
                    if (beat_valid) begin
                        acc[idx] <= sum;
                        if (bank_beat.eos) begin
                            pair_cnt <= '0;
                            // hold keeps the sums and waits for the next stream
                            if (bank_beat.cmd == edge_aggr_pkg::CMD_HOLD) begin
                                state <= ST_IDLE;
                            end else begin
                                state <= ST_DRAIN;
                            end
                        end else begin
                            pair_cnt <= pair_cnt + 1'b1;
                            state    <= ST_STREAM;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (take) begin
                        if (last_pair) begin
                            acc      <= '0;
                            pair_cnt <= '0;
                            state    <= ST_RELEASE;
                        end else begin
                            pair_cnt <= pair_cnt + 1'b1;
                        end
                    end
                end
                ST_RELEASE: begin
                    // req is already low, wait for the arbiter to drop ack
                    if (!ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // stream length, node id and command of the last stream
    always_ff @(posedge clk) begin
        if (beat_valid && (state == ST_IDLE || state == ST_STREAM)) begin
            cur_node <= bank_beat.node_id;
            if (bank_beat.eos) begin
                pair_len <= pair_cnt + 1'b1;
                cur_cmd  <= bank_beat.cmd;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bank_drain_arbiter.sv ====
// round-robin four-phase arbiter moving one bank result stream to the output
`default_nettype none

module bank_drain_arbiter (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic [edge_aggr_pkg::NUM_BANKS-1:0]                  req,
    input  edge_aggr_pkg::bank_beat_t [edge_aggr_pkg::NUM_BANKS-1:0] bank_beats,
    output logic [edge_aggr_pkg::NUM_BANKS-1:0]                  ack,
    output logic [edge_aggr_pkg::NUM_BANKS-1:0]                  take,
    output logic                                                 out_valid,
    output edge_aggr_pkg::bank_beat_t                            out_beat,
    input  logic                                                 out_ready
);

    // grant in progress and the bank it belongs to
    logic                                 active;
    logic [edge_aggr_pkg::BANK_SEL_W-1:0] cur;

    logic [edge_aggr_pkg::BANK_SEL_W-1:0] cand;
    logic [edge_aggr_pkg::BANK_SEL_W-1:0] next_sel;
    logic                                 next_found;

    // search starts one past the last bank served
    always_comb begin
        cand       = cur;
        next_sel   = cur;
        next_found = 1'b0;
        for (int off = 1; off <= edge_aggr_pkg::NUM_BANKS; off++) begin
            cand = cur + off[edge_aggr_pkg::BANK_SEL_W-1:0];
            if (!next_found && req[cand]) begin
                next_sel   = cand;
                next_found = 1'b1;
            end
        end
    end

    always_comb begin
        ack = '0;
        if (active) begin
            ack[cur] = 1'b1;
        end
    end

    // req stays high until the eos take, so it frames the stream
    assign out_valid = active && req[cur];
    assign out_beat  = bank_beats[cur];

    always_comb begin
        take      = '0;
        take[cur] = out_valid && out_ready;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            // first pick lands on bank 0
            cur    <= '1;
        end else if (!active) begin
            if (next_found) begin
                active <= 1'b1;
                cur    <= next_sel;
            end
        end else if (!req[cur]) begin
            // bank has dropped req, release the handshake
            active <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== edge_aggr_top.sv ====
// edge aggregation top with dispatcher, accumulation banks and drain arbiter
`default_nettype none

module edge_aggr_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  edge_aggr_pkg::edge_beat_t in_beat,
    output logic                      in_ready,
    output logic                      out_valid,
    output edge_aggr_pkg::bank_beat_t out_beat,
    input  logic                      out_ready
);

    logic [edge_aggr_pkg::NUM_BANKS-1:0]                      bank_busy;
    logic [edge_aggr_pkg::NUM_BANKS-1:0]                      beat_valid;
    edge_aggr_pkg::edge_beat_t                                bank_beat;
    logic [edge_aggr_pkg::NUM_BANKS-1:0]                      req;
    logic [edge_aggr_pkg::NUM_BANKS-1:0]                      ack;
    logic [edge_aggr_pkg::NUM_BANKS-1:0]                      take;
    edge_aggr_pkg::bank_beat_t [edge_aggr_pkg::NUM_BANKS-1:0] bank_beats;

    edge_bank_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_ready   (in_ready),
        .bank_busy  (bank_busy),
        .beat_valid (beat_valid),
        .bank_beat  (bank_beat)
    );

    for (genvar b = 0; b < edge_aggr_pkg::NUM_BANKS; b++) begin : g_bank
        edge_bank u_bank (
            .clk        (clk),
            .reset      (reset),
            .beat_valid (beat_valid[b]),
            .bank_beat  (bank_beat),
            .busy       (bank_busy[b]),
            .req        (req[b]),
            .ack        (ack[b]),
            .take       (take[b]),
            .out_beat   (bank_beats[b])
        );
    end

    bank_drain_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .bank_beats (bank_beats),
        .ack        (ack),
        .take       (take),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// ==== edge_aggr_clock.sv ====
// testbench clock generator with a 10 ns period
`default_nettype none

module edge_aggr_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

// ==== edge_aggr_checker.sv ====
// protocol checker for the drain arbiter req/ack exchange and output framing
`default_nettype none

module edge_aggr_checker (
    input logic                                                     clk,
    input logic                                                     reset,
    input logic [edge_aggr_pkg::NUM_BANKS-1:0]                      req,
    input logic [edge_aggr_pkg::NUM_BANKS-1:0]                      ack,
    input logic                                                     out_valid,
    input logic                                                     out_ready,
    input edge_aggr_pkg::bank_beat_t                                out_beat
);

    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions
    int fail_count = 0;

    ack_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(ack))
        else begin
            $error("more than one ack high");
            fail_count++;
        end

    // out_valid holds until the eos beat leaves
    stream_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !(out_ready && out_beat.eos) |=> out_valid)
        else begin
            $error("output stream broken before eos");
            fail_count++;
        end

    for (genvar b = 0; b < edge_aggr_pkg::NUM_BANKS; b++) begin : g_hs
        ack_rise: assert property (@(posedge clk) disable iff (reset)
            $rose(ack[b]) |-> req[b])
            else begin
                $error("ack rose without req");
                fail_count++;
            end
        ack_fall: assert property (@(posedge clk) disable iff (reset)
            $fell(ack[b]) |-> $past(!req[b]))
            else begin
                $error("ack fell while req still high");
                fail_count++;
            end
    end

endmodule

bind bank_drain_arbiter edge_aggr_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .ack       (ack),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
);

`default_nettype wire

// ==== edge_aggr_tb.sv ====
// testbench for the edge aggregation subsystem with a reference model
`default_nettype none

module edge_aggr_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // beats sent over all tests
    localparam int TOTAL_BEATS = 82;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 500;

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    edge_aggr_pkg::edge_beat_t in_beat;
    logic                      in_ready;
    logic                      out_valid;
    edge_aggr_pkg::bank_beat_t out_beat;
    logic                      out_ready;

    bit [15:0]                 ref_sum [1024][16];
    edge_aggr_pkg::bank_beat_t exp_q [1024][$];
    int                        pending;
    int                        errors;
    int                        tests_passed;
    int                        tests_failed;
    int                        err_mark;
    int                        checker_mark;
    bit                        random_ready;
    bit                        stall;
    bit                        in_stream;
    logic [9:0]                stream_node;

    edge_aggr_clock u_clock (.clk(clk));

    edge_aggr_top UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // adds one stream into the node sums and queues the result on write-back or final
    function automatic void model_stream(input int node, input int n,
                                         input edge_aggr_pkg::aggr_cmd_t cmd,
                                         input edge_aggr_pkg::fv_pair_t d [8]);
        edge_aggr_pkg::bank_beat_t e;
        for (int i = 0; i < n; i++) begin
            ref_sum[node][2*i]   = ref_sum[node][2*i] + d[i][0];
            ref_sum[node][2*i+1] = ref_sum[node][2*i+1] + d[i][1];
        end
        if (cmd != edge_aggr_pkg::CMD_HOLD) begin
            for (int i = 0; i < n; i++) begin
                e.node_id = node[9:0];
                e.sos     = (i == 0);
                e.eos     = (i == n - 1);
                e.kind    = (cmd == edge_aggr_pkg::CMD_FINAL) ?
                            edge_aggr_pkg::KIND_FINAL : edge_aggr_pkg::KIND_PARTIAL;
                e.data[0] = ref_sum[node][2*i];
                e.data[1] = ref_sum[node][2*i+1];
                exp_q[node].push_back(e);
                pending++;
            end
            for (int k = 0; k < 16; k++) begin
                ref_sum[node][k] = '0;
            end
        end
    endfunction

    task automatic drive_beat(input edge_aggr_pkg::edge_beat_t b);
        @(negedge clk);
        in_valid = 1'b1;
        in_beat  = b;
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    task automatic send_stream(input int node, input int n,
                               input edge_aggr_pkg::aggr_cmd_t cmd);
        edge_aggr_pkg::fv_pair_t   d [8];
        edge_aggr_pkg::edge_beat_t b;
        for (int i = 0; i < n; i++) begin
            d[i] = $urandom;
        end
        model_stream(node, n, cmd, d);
        for (int i = 0; i < n; i++) begin
            b.node_id = node[9:0];
            b.sos     = (i == 0);
            b.eos     = (i == n - 1);
            b.cmd     = (i == n - 1) ? cmd : edge_aggr_pkg::CMD_HOLD;
            b.data    = d[i];
            drive_beat(b);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        wait (pending == 0);
        repeat (4) @(posedge clk);
        // protocol assertion failures of the bound checker count for this test
        errors       = errors + UUT.u_arbiter.u_checker.fail_count - checker_mark;
        checker_mark = UUT.u_arbiter.u_checker.fail_count;
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    always @(negedge clk) begin
        out_ready <= random_ready ? 1'($urandom % 2) : !stall;
    end

    // compares every transferred output beat with the head of its node queue
    always @(posedge clk) begin
        edge_aggr_pkg::bank_beat_t e;
        if (!reset && out_valid && out_ready) begin
            assert (!in_stream || out_beat.node_id == stream_node)
                else begin
                    $display("output stream for node %0d interrupted by node %0d",
                             stream_node, out_beat.node_id);
                    errors++;
                end
            in_stream   = !out_beat.eos;
            stream_node = out_beat.node_id;
            if (exp_q[out_beat.node_id].size() == 0) begin
                $display("unexpected output beat for node %0d", out_beat.node_id);
                errors++;
            end else begin
                e = exp_q[out_beat.node_id].pop_front();
                pending--;
                assert (out_beat.data == e.data)
                    else begin
                        $display("error out_beat.data got %h expected %h",
                                 out_beat.data, e.data);
                        errors++;
                    end
                assert (out_beat.sos == e.sos && out_beat.eos == e.eos)
                    else begin
                        $display("error out_beat.sos/eos got %h/%h expected %h/%h",
                                 out_beat.sos, out_beat.eos, e.sos, e.eos);
                        errors++;
                    end
                assert (out_beat.kind == e.kind)
                    else begin
                        $display("error out_beat.kind got %h expected %h",
                                 out_beat.kind, e.kind);
                        errors++;
                    end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog timeout, output results still missing");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(32'h233e3d35));
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_beat      = '0;
        out_ready    = 1'b0;
        random_ready = 1'b0;
        stall        = 1'b0;
        in_stream    = 1'b0;
        stream_node  = '0;
        pending      = 0;
        errors       = 0;
        err_mark     = 0;
        checker_mark = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        send_stream(0, 4, edge_aggr_pkg::CMD_FINAL);
        end_test("single_final");

        for (int s = 0; s < 3; s++) begin
            send_stream(3, 4, edge_aggr_pkg::CMD_HOLD);
        end
        send_stream(3, 4, edge_aggr_pkg::CMD_FINAL);
        end_test("hold_then_final");

        send_stream(2, 3, edge_aggr_pkg::CMD_WRITEBACK);
        send_stream(2, 3, edge_aggr_pkg::CMD_FINAL);
        end_test("writeback_then_final");

        // streams alternate over all four banks
        for (int n = 4; n < 8; n++) begin
            send_stream(n, 2, edge_aggr_pkg::CMD_HOLD);
        end
        for (int n = 4; n < 8; n++) begin
            send_stream(n, 2, edge_aggr_pkg::CMD_FINAL);
        end
        end_test("all_banks");

        random_ready = 1'b1;
        for (int n = 8; n < 16; n++) begin
            send_stream(n, 4, edge_aggr_pkg::CMD_FINAL);
        end
        end_test("random_ready");
        random_ready = 1'b0;

        // bank 1 kept draining while node 17 asks for it
        stall = 1'b1;
        send_stream(1, 4, edge_aggr_pkg::CMD_FINAL);
        in_beat.node_id = 10'd17;
        in_beat.sos     = 1'b1;
        in_valid        = 1'b1;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            #1;
            assert (!in_ready)
                else begin
                    $display("in_ready high while bank 1 is still draining");
                    errors++;
                end
        end
        stall = 1'b0;
        send_stream(17, 4, edge_aggr_pkg::CMD_FINAL);
        end_test("busy_bank");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== edge_aggr_top.f ====
edge_aggr_pkg.sv
edge_bank_dispatch.sv
edge_bank.sv
bank_drain_arbiter.sv
edge_aggr_top.sv
edge_aggr_clock.sv
edge_aggr_checker.sv
edge_aggr_tb.sv

// ==== Bender.yml ====
package:
  name: edge_aggr

sources:
  - edge_aggr_pkg.sv
  - edge_bank_dispatch.sv
  - edge_bank.sv
  - bank_drain_arbiter.sv
  - edge_aggr_top.sv
  - target: test
    files:
      - edge_aggr_clock.sv
      - edge_aggr_checker.sv
      - edge_aggr_tb.sv
